// ==== bench/tb_cam_tracker.sv ====
// camera tracker testbench
// writes frames over the camera port, checks the displayed raster against a
// reference model, and checks the per-frame direction report
`include "cam_params.svh"

module tb_cam_tracker;
  timeunit 1ns;
  timeprecision 1ps;

  // 8 checked frames of up to 2*768 byte strobes and two 1320-cycle rasters
  // come to about 33400 cycles, plus margin
  localparam int TIMEOUT_CYCLES = 40000;

  // scaled raster as seen at the outputs
  localparam int H_TOTAL      = `CAM_WIDTH + `H_FRONT + `H_SYNC + `H_BACK;
  localparam int V_TOTAL      = `CAM_HEIGHT + `V_FRONT + `V_SYNC + `V_BACK;
  localparam int H_SYNC_START = `CAM_WIDTH + `H_FRONT;
  localparam int V_SYNC_START = `CAM_HEIGHT + `V_FRONT;

  logic          clk_25_vga;
  logic          arst_n;
  logic          cam_vsync;
  logic          cam_href;
  logic          cam_byte_valid;
  logic [7:0]    cam_data;
  logic [7:0]    vga_r;
  logic [7:0]    vga_g;
  logic [7:0]    vga_b;
  logic          vga_hsync;
  logic          vga_vsync;
  logic          vga_blank_n;
  cam_pkg::dir_t direction;
  logic          dir_valid;

  // expected frame contents in raster order
  cam_pkg::pixel_t model [`FB_DEPTH];
  logic [31:0]     rng = 32'hecd5;
  int              errors = 0;
  int              cycles = 0;
  int              frames_req = 0;
  int              frames_done = 0;
  // compare process state
  logic            in_frame = 1'b0;
  logic            vsync_prev = 1'b1;
  int              pix_idx = 0;
  int              h_pos = 0;
  int              v_pos = 0;

  cam_tracker_top u_dut (
    .clk_25_vga, .arst_n, .cam_vsync, .cam_href, .cam_byte_valid, .cam_data,
    .vga_r, .vga_g, .vga_b, .vga_hsync, .vga_vsync, .vga_blank_n,
    .direction, .dir_valid);

  initial begin
    clk_25_vga = 1'b0;
    forever #10 clk_25_vga = ~clk_25_vga;
  end

  function automatic logic [31:0] xorshift32(input logic [31:0] s);
    s = s ^ (s << 13);
    s = s ^ (s >> 17);
    s = s ^ (s << 5);
    return s;
  endfunction

  function automatic logic [31:0] rand_word();
    rng = xorshift32(rng);
    return rng;
  endfunction

  function automatic bit is_orange(input cam_pkg::pixel_t p);
    return (p.red >= `ORANGE_R_MIN) && (p.green >= `ORANGE_G_MIN) &&
           (p.green <= `ORANGE_G_MAX) && (p.blue <= `ORANGE_B_MAX);
  endfunction

  // expected dac color of an active pixel
  function automatic logic [23:0] ref_rgb(input cam_pkg::pixel_t p);
    if (is_orange(p))
      return cam_pkg::HIGHLIGHT;
    return {p.red, p.red, p.green, p.green, p.blue, p.blue};
  endfunction

  // region counts over the model with ties going left then center
  function automatic cam_pkg::dir_t ref_direction();
    int l;
    int c;
    int r;
    int col;
    l = 0;
    c = 0;
    r = 0;
    for (int i = 0; i < `FB_DEPTH; i++) begin
      col = i % `CAM_WIDTH;
      if (is_orange(model[i])) begin
        if (col < `REGION_SPLIT_1)
          l++;
        else if (col < `REGION_SPLIT_2)
          c++;
        else
          r++;
      end
    end
    if (l + c + r < `MIN_TARGET_PIXELS)
      return cam_pkg::DIR_NONE;
    if (l >= c && l >= r)
      return cam_pkg::DIR_LEFT;
    if (c >= r)
      return cam_pkg::DIR_CENTER;
    return cam_pkg::DIR_RIGHT;
  endfunction

  function automatic cam_pkg::pixel_t rand_plain();
    logic [31:0]     w;
    cam_pkg::pixel_t p;
    w = rand_word();
    p = w[11:0];
    // push blue out of range so it never matches
    if (is_orange(p))
      p.blue = 4'hf;
    return p;
  endfunction

  function automatic cam_pkg::pixel_t rand_orange();
    logic [31:0]     w;
    cam_pkg::pixel_t p;
    w = rand_word();
    p.red   = 4'd12 + {2'b00, w[1:0]};
    p.green = 4'd4 + (w[7:4] % 4'd6);
    p.blue  = w[11:8] % 4'd5;
    return p;
  endfunction

  task automatic check_value(input string name, input logic [31:0] got,
                             input logic [31:0] exp);
    if (got !== exp) begin
      errors++;
      $display("MISMATCH %s: got %0h, expected %0h", name, got, exp);
    end
  endtask

  task automatic check_reset_outputs();
    check_value("vga_blank_n", vga_blank_n, 1'b0);
    check_value("dir_valid", dir_valid, 1'b0);
    check_value("vga_hsync", vga_hsync, 1'b1);
    check_value("vga_vsync", vga_vsync, 1'b1);
  endtask

  // inputs change 2 ns after the rising edge
  task automatic next_edge();
    @(posedge clk_25_vga);
    #2;
  endtask

  task automatic drive_byte(input logic [7:0] data, input logic href);
    cam_href       = href;
    cam_byte_valid = 1'b1;
    cam_data       = data;
    next_edge();
    cam_byte_valid = 1'b0;
  endtask

  task automatic pulse_vsync();
    cam_href  = 1'b0;
    cam_vsync = 1'b1;
    next_edge();
    next_edge();
    cam_vsync = 1'b0;
    next_edge();
  endtask

  task automatic fill_plain();
    for (int i = 0; i < `FB_DEPTH; i++)
      model[i] = rand_plain();
  endtask

  task automatic place_block(input int c0, input int c1, input int r0, input int r1);
    for (int r = r0; r <= r1; r++)
      for (int c = c0; c <= c1; c++)
        model[r * `CAM_WIDTH + c] = rand_orange();
  endtask

  // partial frame of junk that the next vsync cuts short
  task automatic send_junk_pixels(input int n);
    logic [31:0] w;
    pulse_vsync();
    repeat (n) begin
      w = rand_word();
      drive_byte(w[7:0], 1'b1);
      drive_byte(w[15:8], 1'b1);
    end
    cam_href = 1'b0;
  endtask

  // framing adds href-low strobes between lines and inside one pair per line
  task automatic send_frame(input bit framing);
    logic [31:0]     w;
    cam_pkg::pixel_t p;
    pulse_vsync();
    for (int r = 0; r < `CAM_HEIGHT; r++) begin
      for (int c = 0; c < `CAM_WIDTH; c++) begin
        p = model[r * `CAM_WIDTH + c];
        w = rand_word();
        // high nibble of the red byte is don't care
        drive_byte({w[7:4], p.red}, 1'b1);
        if (framing && c == 13)
          drive_byte(w[15:8], 1'b0);
        drive_byte({p.green, p.blue}, 1'b1);
      end
      cam_href = 1'b0;
      if (framing) begin
        drive_byte(w[23:16], 1'b0);
        drive_byte(w[31:24], 1'b0);
      end
      next_edge();
    end
    next_edge();
    next_edge();
  endtask

  task automatic run_frame(input bit framing);
    send_frame(framing);
    frames_req++;
    wait (frames_done == frames_req);
  endtask

  // compare process samples outputs mid-cycle
  always @(negedge clk_25_vga) begin
    if (frames_done < frames_req) begin
      if (!in_frame) begin
        // displayed frame starts after the vsync fall
        if (vsync_prev && !vga_vsync) begin
          in_frame = 1'b1;
          pix_idx  = 0;
          // vsync falls at the first column of its first line
          h_pos    = 0;
          v_pos    = V_SYNC_START;
        end
      end else begin
        if (h_pos == H_TOTAL - 1) begin
          h_pos = 0;
          v_pos = (v_pos == V_TOTAL - 1) ? 0 : v_pos + 1;
        end else begin
          h_pos++;
        end
        check_value("vga_hsync", vga_hsync,
                    !(h_pos >= H_SYNC_START && h_pos < H_SYNC_START + `H_SYNC));
        check_value("vga_vsync", vga_vsync,
                    !(v_pos >= V_SYNC_START && v_pos < V_SYNC_START + `V_SYNC));
        if (vga_blank_n && pix_idx < `FB_DEPTH) begin
          check_value($sformatf("vga_rgb[%0d]", pix_idx), {vga_r, vga_g, vga_b},
                      ref_rgb(model[pix_idx]));
          pix_idx++;
        end else if (vga_blank_n) begin
          errors++;
          $display("more active pixels than the frame holds in frame %0d", frames_done);
        end else begin
          check_value("vga_rgb_blank", {vga_r, vga_g, vga_b}, 24'h0);
        end
        // report for this frame rather than the one before it
        if (dir_valid && pix_idx == `FB_DEPTH) begin
          check_value("direction", direction, ref_direction());
          in_frame = 1'b0;
          frames_done++;
        end
      end
    end
    vsync_prev = vga_vsync;
  end

  always @(posedge clk_25_vga) begin
    cycles++;
    if (cycles >= TIMEOUT_CYCLES) begin
      $display("timeout after %0d cycles with %0d of %0d frames checked",
               cycles, frames_done, frames_req);
      $display("=== FAIL ===");
      $finish;
    end
  end

  initial begin
    arst_n         = 1'b0;
    cam_vsync      = 1'b0;
    cam_href       = 1'b0;
    cam_byte_valid = 1'b0;
    cam_data       = 8'h00;
    // outputs idle through reset and at its release
    repeat (3) begin
      next_edge();
      check_reset_outputs();
    end
    arst_n = 1'b1;
    @(negedge clk_25_vga);
    check_reset_outputs();

    // plain pixels only
    fill_plain();
    run_frame(1'b0);

    // scattered orange
    fill_plain();
    repeat (40)
      model[rand_word() % `FB_DEPTH] = rand_orange();
    run_frame(1'b0);

    // left, center and right blocks
    fill_plain();
    place_block(2, 5, 4, 7);
    run_frame(1'b0);
    fill_plain();
    place_block(14, 17, 9, 12);
    run_frame(1'b0);
    fill_plain();
    place_block(25, 28, 15, 18);
    run_frame(1'b0);

    // five pixels below the detection count
    fill_plain();
    place_block(3, 7, 12, 12);
    run_frame(1'b0);

    // six left against six right
    fill_plain();
    place_block(1, 3, 10, 11);
    place_block(27, 29, 10, 11);
    run_frame(1'b0);

    // junk cut off by vsync and then a frame with href-low strobes
    send_junk_pixels(100);
    fill_plain();
    place_block(14, 17, 2, 5);
    run_frame(1'b1);

    $display("errors %0d, frames checked %0d", errors, frames_done);
    if (errors == 0)
      $display("=== PASS ===");
    else
      $display("=== FAIL ===");
    $finish;
  end

endmodule

// ==== include/cam_params.svh ====
// camera tracker parameters
// frame size, scaled vga timing, orange thresholds and region splits
`ifndef CAM_PARAMS_SVH
`define CAM_PARAMS_SVH

// scaled frame, also the vga active area
`define CAM_WIDTH  32
`define CAM_HEIGHT 24

// frame buffer, one word per pixel
`define FB_DEPTH  768
`define FB_ADDR_W 10

// porches and sync widths, line of 44 cycles, frame of 30 lines
`define H_FRONT 4
`define H_SYNC  4
`define H_BACK  4
`define V_FRONT 2
`define V_SYNC  2
`define V_BACK  2

// orange rule on 4-bit components
`define ORANGE_R_MIN 12
`define ORANGE_G_MIN 4
`define ORANGE_G_MAX 9
`define ORANGE_B_MAX 4

// column boundaries left | center | right
`define REGION_SPLIT_1 11
`define REGION_SPLIT_2 22

// least orange count for a detection
`define MIN_TARGET_PIXELS 6

`endif

// ==== project.f ====
+incdir+include
rtl/cam_pkg.sv
rtl/ov7670_capture.sv
rtl/frame_buffer.sv
rtl/vga_timing.sv
rtl/target_finder.sv
rtl/target_locator.sv
rtl/cam_tracker_top.sv
bench/tb_cam_tracker.sv

// ==== rtl/cam_pkg.sv ====
// camera tracker types
// pixel formats, direction code and the highlight color
package cam_pkg;

  // rgb444 as stored in the frame buffer
  typedef struct packed {
    logic [3:0] red;
    logic [3:0] green;
    logic [3:0] blue;
  } pixel_t;

  // 24-bit color as driven to the dac
  typedef struct packed {
    logic [7:0] red;
    logic [7:0] green;
    logic [7:0] blue;
  } rgb24_t;

  // where the target sits in the frame
  typedef enum logic [1:0] {
    DIR_NONE   = 2'd0,
    DIR_LEFT   = 2'd1,
    DIR_CENTER = 2'd2,
    DIR_RIGHT  = 2'd3
  } dir_t;

  // replaces every matched pixel
  localparam rgb24_t HIGHLIGHT = '{red: 8'hff, green: 8'h80, blue: 8'h00};

endpackage

// ==== rtl/cam_tracker_top.sv ====
// camera tracker top
// camera capture into the frame buffer, vga readback, orange highlight
// and per-frame direction report
`include "cam_params.svh"

module cam_tracker_top (
  input  logic          clk_25_vga,
  input  logic          arst_n,
  input  logic          cam_vsync,
  input  logic          cam_href,
  input  logic          cam_byte_valid,
  input  logic [7:0]    cam_data,
  output logic [7:0]    vga_r,
  output logic [7:0]    vga_g,
  output logic [7:0]    vga_b,
  output logic          vga_hsync,
  output logic          vga_vsync,
  output logic          vga_blank_n,
  output cam_pkg::dir_t direction,
  output logic          dir_valid
);

  // capture side
  logic                  wr_en;
  logic [`FB_ADDR_W-1:0] wr_addr;
  cam_pkg::pixel_t       wr_pixel;
  // readback side, sync and col one cycle late
  logic [`FB_ADDR_W-1:0] rd_addr;
  cam_pkg::pixel_t       rd_pixel;
  logic                  hsync_d1;
  logic                  vsync_d1;
  logic                  active_d1;
  logic [4:0]            col_d1;
  // finder to dac and locator
  cam_pkg::rgb24_t       rgb;
  logic                  is_target;
  logic [4:0]            col_d2;

  assign vga_r = rgb.red;
  assign vga_g = rgb.green;
  assign vga_b = rgb.blue;

  ov7670_capture u_capture (
    .clk_25_vga, .arst_n, .cam_vsync, .cam_href, .cam_byte_valid, .cam_data,
    .wr_en, .wr_addr, .wr_pixel);

  frame_buffer #(.word_t(cam_pkg::pixel_t), .DEPTH(`FB_DEPTH)) u_frame_buffer (
    .clk_25_vga, .wr_en, .wr_addr, .wr_data(wr_pixel), .rd_addr, .rd_data(rd_pixel));

  vga_timing u_vga_timing (
    .clk_25_vga, .arst_n, .rd_addr,
    .hsync(hsync_d1), .vsync(vsync_d1), .active(active_d1), .col(col_d1));

  target_finder u_finder (
    .clk_25_vga, .arst_n, .pixel_in(rd_pixel),
    .active_in(active_d1), .hsync_in(hsync_d1), .vsync_in(vsync_d1), .col_in(col_d1),
    .rgb_out(rgb), .is_target, .active_out(vga_blank_n),
    .hsync_out(vga_hsync), .vsync_out(vga_vsync), .col_out(col_d2));

  target_locator u_locator (
    .clk_25_vga, .arst_n, .is_target, .active(vga_blank_n), .col(col_d2),
    .vsync(vga_vsync), .direction, .dir_valid);

endmodule

// ==== rtl/frame_buffer.sv ====
// frame buffer
// single-clock dual-port memory, registered read, payload type set per instance
`include "cam_params.svh"

module frame_buffer #(
  parameter type word_t = cam_pkg::pixel_t,
  parameter int  DEPTH  = `FB_DEPTH,
  parameter int  ADDR_W = $clog2(DEPTH)
) (
  input  logic              clk_25_vga,
  input  logic              wr_en,
  input  logic [ADDR_W-1:0] wr_addr,
  input  word_t             wr_data,
  input  logic [ADDR_W-1:0] rd_addr,
  output word_t             rd_data
);

  word_t mem [DEPTH];

  // write port
  always_ff @(posedge clk_25_vga) begin
    if (wr_en)
      mem[wr_addr] <= wr_data;
  end

  // read port, same-address collision returns old word
  always_ff @(posedge clk_25_vga) begin
    rd_data <= mem[rd_addr];
  end

  // capture must drop writes beyond the last word
  a_wr_in_range : assert property (@(posedge clk_25_vga)
    wr_en |-> (wr_addr < DEPTH));

endmodule

// ==== rtl/ov7670_capture.sv ====
// ov7670 capture
// pairs rgb444 camera bytes into pixels and writes them to the frame buffer
`include "cam_params.svh"

module ov7670_capture (
  input  logic                  clk_25_vga,
  input  logic                  arst_n,
  input  logic                  cam_vsync,
  input  logic                  cam_href,
  input  logic                  cam_byte_valid,
  input  logic [7:0]            cam_data,
  output logic                  wr_en,
  output logic [`FB_ADDR_W-1:0] wr_addr,
  output cam_pkg::pixel_t       wr_pixel
);

  // low = waiting for the red byte
  logic       byte_phase;
  logic [3:0] red_hold;

  // byte only counts inside a line
  logic       byte_take;
  assign byte_take = cam_byte_valid & cam_href;

  always_ff @(posedge clk_25_vga or negedge arst_n) begin
    if (!arst_n) begin
      byte_phase <= 1'b0;
      wr_en      <= 1'b0;
      wr_addr    <= '0;
    end else if (cam_vsync) begin
      // new frame restarts at address 0
      byte_phase <= 1'b0;
      wr_en      <= 1'b0;
      wr_addr    <= '0;
    end else begin
      // advance after the write has been presented
      if (wr_en)
        wr_addr <= wr_addr + 1'b1;
      // writes past the end of the buffer are dropped
      wr_en <= byte_take & byte_phase & (wr_addr < `FB_DEPTH);
      if (byte_take)
        byte_phase <= ~byte_phase;
    end
  end

  // payload, first byte low nibble is red
  always_ff @(posedge clk_25_vga) begin
    if (byte_take && !byte_phase)
      red_hold <= cam_data[3:0];
    if (byte_take && byte_phase)
      wr_pixel <= '{red: red_hold, green: cam_data[7:4], blue: cam_data[3:0]};
  end

  // at most one pixel per byte pair
  a_wr_single : assert property (@(posedge clk_25_vga) disable iff (!arst_n)
    wr_en |=> !wr_en);

endmodule

// ==== rtl/target_finder.sv ====
// target finder
// expands rgb444 to 24-bit color and paints orange pixels with the highlight
`include "cam_params.svh"

module target_finder (
  input  logic            clk_25_vga,
  input  logic            arst_n,
  input  cam_pkg::pixel_t pixel_in,
  input  logic            active_in,
  input  logic            hsync_in,
  input  logic            vsync_in,
  input  logic [4:0]      col_in,
  output cam_pkg::rgb24_t rgb_out,
  output logic            is_target,
  output logic            active_out,
  output logic            hsync_out,
  output logic            vsync_out,
  output logic [4:0]      col_out
);

  cam_pkg::rgb24_t expanded;
  logic            match;

  // nibble doubled so 4'hf maps to 8'hff
  assign expanded = '{red:   {pixel_in.red,   pixel_in.red},
                      green: {pixel_in.green, pixel_in.green},
                      blue:  {pixel_in.blue,  pixel_in.blue}};

  // strong red, mid green, little blue
  assign match = active_in &&
                 (pixel_in.red   >= `ORANGE_R_MIN) &&
                 (pixel_in.green >= `ORANGE_G_MIN) &&
                 (pixel_in.green <= `ORANGE_G_MAX) &&
                 (pixel_in.blue  <= `ORANGE_B_MAX);

  always_ff @(posedge clk_25_vga or negedge arst_n) begin
    if (!arst_n) begin
      rgb_out    <= '0;
      is_target  <= 1'b0;
      active_out <= 1'b0;
      hsync_out  <= 1'b1;
      vsync_out  <= 1'b1;
      col_out    <= '0;
    end else begin
      // blanked pixels go out black
      if (!active_in)
        rgb_out <= '0;
      else if (match)
        rgb_out <= cam_pkg::HIGHLIGHT;
      else
        rgb_out <= expanded;
      is_target  <= match;
      active_out <= active_in;
      hsync_out  <= hsync_in;
      vsync_out  <= vsync_in;
      col_out    <= col_in;
    end
  end

endmodule

// ==== rtl/target_locator.sv ====
// target locator
// counts orange pixels in left, center and right columns
// reports the winning region once per frame at the start of vsync
`include "cam_params.svh"

module target_locator (
  input  logic          clk_25_vga,
  input  logic          arst_n,
  input  logic          is_target,
  input  logic          active,
  input  logic [4:0]    col,
  input  logic          vsync,
  output cam_pkg::dir_t direction,
  output logic          dir_valid
);

  // a full frame of hits fits in 10 bits
  logic [9:0]  cnt_left;
  logic [9:0]  cnt_center;
  logic [9:0]  cnt_right;
  logic [11:0] total;
  logic        vsync_d;
  logic        frame_end;

  assign total     = cnt_left + cnt_center + cnt_right;
  // sync is active low, so the fall starts the pulse
  assign frame_end = vsync_d & ~vsync;

  always_ff @(posedge clk_25_vga or negedge arst_n) begin
    if (!arst_n) begin
      cnt_left   <= '0;
      cnt_center <= '0;
      cnt_right  <= '0;
      vsync_d    <= 1'b1;
      direction  <= cam_pkg::DIR_NONE;
      dir_valid  <= 1'b0;
    end else begin
      vsync_d   <= vsync;
      dir_valid <= frame_end;
      if (frame_end) begin
        // ties go left, then center
        if (total < `MIN_TARGET_PIXELS)
          direction <= cam_pkg::DIR_NONE;
        else if (cnt_left >= cnt_center && cnt_left >= cnt_right)
          direction <= cam_pkg::DIR_LEFT;
        else if (cnt_center >= cnt_right)
          direction <= cam_pkg::DIR_CENTER;
        else
          direction <= cam_pkg::DIR_RIGHT;
        cnt_left   <= '0;
        cnt_center <= '0;
        cnt_right  <= '0;
      end else if (active && is_target) begin
        if (col < `REGION_SPLIT_1)
          cnt_left <= cnt_left + 1'b1;
        else if (col < `REGION_SPLIT_2)
          cnt_center <= cnt_center + 1'b1;
        else
          cnt_right <= cnt_right + 1'b1;
      end
    end
  end

  // one report per vsync pulse
  a_dir_pulse : assert property (@(posedge clk_25_vga) disable iff (!arst_n)
    dir_valid |=> !dir_valid);

endmodule

// ==== rtl/vga_timing.sv ====
// vga timing
// raster counters, active-low syncs and frame buffer read address
// sync, active and col leave one cycle late to line up with read data
`include "cam_params.svh"

module vga_timing (
  input  logic                  clk_25_vga,
  input  logic                  arst_n,
  output logic [`FB_ADDR_W-1:0] rd_addr,
  output logic                  hsync,
  output logic                  vsync,
  output logic                  active,
  output logic [4:0]            col
);

  localparam int H_TOTAL = `CAM_WIDTH + `H_FRONT + `H_SYNC + `H_BACK;
  localparam int V_TOTAL = `CAM_HEIGHT + `V_FRONT + `V_SYNC + `V_BACK;
  localparam int H_W     = $clog2(H_TOTAL);
  localparam int V_W     = $clog2(V_TOTAL);

  logic [H_W-1:0] h_cnt;
  logic [V_W-1:0] v_cnt;
  logic           h_end;
  logic           active_now;
  logic           hsync_now;
  logic           vsync_now;

  assign h_end = (h_cnt == H_TOTAL - 1);

  // active area first, then front porch, sync, back porch
  assign active_now = (h_cnt < `CAM_WIDTH) && (v_cnt < `CAM_HEIGHT);
  assign hsync_now  = !((h_cnt >= `CAM_WIDTH + `H_FRONT) &&
                        (h_cnt <  `CAM_WIDTH + `H_FRONT + `H_SYNC));
  assign vsync_now  = !((v_cnt >= `CAM_HEIGHT + `V_FRONT) &&
                        (v_cnt <  `CAM_HEIGHT + `V_FRONT + `V_SYNC));

  // horizontal and vertical counters
  always_ff @(posedge clk_25_vga or negedge arst_n) begin
    if (!arst_n) begin
      h_cnt <= '0;
      v_cnt <= '0;
    end else if (h_end) begin
      h_cnt <= '0;
      if (v_cnt == V_TOTAL - 1)
        v_cnt <= '0;
      else
        v_cnt <= v_cnt + 1'b1;
    end else begin
      h_cnt <= h_cnt + 1'b1;
    end
  end

  // read address, cleared in vsync and stepped per active pixel
  always_ff @(posedge clk_25_vga or negedge arst_n) begin
    if (!arst_n)
      rd_addr <= '0;
    else if (!vsync_now)
      rd_addr <= '0;
    else if (active_now)
      rd_addr <= rd_addr + 1'b1;
  end

  // one stage to match the buffer read latency
  always_ff @(posedge clk_25_vga or negedge arst_n) begin
    if (!arst_n) begin
      hsync  <= 1'b1;
      vsync  <= 1'b1;
      active <= 1'b0;
      col    <= '0;
    end else begin
      hsync  <= hsync_now;
      vsync  <= vsync_now;
      active <= active_now;
      col    <= h_cnt[4:0];
    end
  end

endmodule

// ==== run_sim.sh ====
#!/bin/sh
# compile and run the camera tracker testbench with Verilator
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -Wno-fatal \
  --top-module tb_cam_tracker -f project.f -o sim_cam_tracker

out=$(./obj_dir/sim_cam_tracker)
echo "$out"

echo "$out" | grep -q "^=== PASS ===$"
